// File: bench/dccm_mem_chk.sv
//**********************************************************
// Bank steering checks, bound into the memory top level
//**********************************************************

module dccm_mem_chk #(
   parameter int NUM_BANKS = 4,
   localparam int BANK_BITS = $clog2(NUM_BANKS)
) (
   input logic                        clk,
   input logic                        reset,
   input dccm_port_pkg::dccm_wr_req_t wr_req,
   input logic [NUM_BANKS-1:0]        bank_we,
   input logic [NUM_BANKS-1:0]        bank_en
);

   timeunit 1ns;
   timeprecision 100ps;

   import dccm_cfg_pkg::*;

   int unsigned max_two_fails = 0;
   int unsigned one_hot_fails = 0;
   int unsigned we_en_fails   = 0;
   int unsigned fail_count;
   logic        wr_aligned;

   assign wr_aligned = wr_req.en &&
      (wr_req.addr_lo[DCCM_OFFSET_BITS +: BANK_BITS] ==
       wr_req.addr_hi[DCCM_OFFSET_BITS +: BANK_BITS]);

   assign fail_count = max_two_fails + one_hot_fails + we_en_fails;

   // Unaligned write spans two banks at most
   a_we_max_two: assert property (@(posedge clk) disable iff (reset)
      $countones(bank_we) <= 2)
      else begin
         $error("more than two bank write enables in one cycle");
         max_two_fails++;
      end

   a_we_one_hot: assert property (@(posedge clk) disable iff (reset)
      wr_aligned |-> $onehot(bank_we))
      else begin
         $error("aligned write did not enable exactly one bank");
         one_hot_fails++;
      end

   // A write always claims the bank port
   a_we_has_en: assert property (@(posedge clk) disable iff (reset)
      (bank_we & ~bank_en) == '0)
      else begin
         $error("bank write enable without access enable");
         we_en_fails++;
      end

endmodule

bind dccm_mem_top dccm_mem_chk #(
   .NUM_BANKS (NUM_BANKS)
) i_chk (
   .clk     (clk),
   .reset   (reset),
   .wr_req  (wr_req),
   .bank_we (bank_we),
   .bank_en (bank_en)
);

// File: bench/dccm_mem_tb.sv
//**********************************************************
// Testbench for the banked data memory
//**********************************************************

module dccm_mem_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import dccm_cfg_pkg::*;
   import dccm_port_pkg::*;

   localparam int NUM_BANKS    = 4;
   localparam int BANK_BITS    = $clog2(NUM_BANKS);
   localparam int WORD_BITS    = DCCM_ADDR_BITS - DCCM_OFFSET_BITS;
   localparam int NUM_WORDS    = 1 << WORD_BITS;
   localparam int CLK_PERIOD   = 4;
   localparam int DRIVE_DELAY  = 1;
   localparam int RESET_CYCLES = 10;

   localparam int N_ALIGNED   = 64;
   localparam int N_UNALIGNED = 64;
   localparam int N_SAME_BANK = 32;
   localparam int N_MIXED     = 32;
   localparam int N_BURST     = 64;

   // Every test cycle, the fill pass and a few idle cycles
   localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_WORDS / 2 + 2 * N_ALIGNED +
      2 * N_UNALIGNED + 3 * N_SAME_BANK + 3 * N_MIXED + N_BURST + 16;
   localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD * 4 + 500;

   localparam dccm_addr_t WORD_STEP = dccm_addr_t'(1 << DCCM_OFFSET_BITS);
   localparam dccm_addr_t BANK_STEP = dccm_addr_t'(NUM_BANKS << DCCM_OFFSET_BITS);

   typedef logic [BANK_BITS-1:0] bank_t;
   typedef logic [WORD_BITS-1:0] word_t;

   // One pending read result and the cycle it shows up in
   typedef struct packed {
      int unsigned due;
      dccm_data_t  lo;
      dccm_data_t  hi;
   } exp_t;

   logic         clk;
   logic         reset;
   dccm_wr_req_t wr_req;
   dccm_rd_req_t rd_req;
   dccm_data_t   rd_data_lo;
   dccm_data_t   rd_data_hi;

   int          seed;
   int unsigned cycle_cnt = 0;
   int          compare_cnt = 0;
   dccm_data_t  ref_mem [NUM_WORDS];
   exp_t        exp_q [$];
   dccm_addr_t  addr_q [$];

   dccm_mem_top #(
      .NUM_BANKS (NUM_BANKS)
   ) i_dut (
      .clk        (clk),
      .reset      (reset),
      .wr_req     (wr_req),
      .rd_req     (rd_req),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   function automatic bank_t bank_num(input dccm_addr_t addr);
      return addr[DCCM_OFFSET_BITS +: BANK_BITS];
   endfunction

   function automatic word_t word_num(input dccm_addr_t addr);
      return addr[DCCM_ADDR_BITS-1:DCCM_OFFSET_BITS];
   endfunction

   function automatic dccm_addr_t addr_of(input word_t wa);
      return {wa, {DCCM_OFFSET_BITS{1'b0}}};
   endfunction

   // Odd multiplier keeps every word of the fill distinct
   function automatic dccm_data_t fill_word(input word_t wa);
      return (dccm_data_t'(wa) * 32'h0001_0193) ^ 32'ha5c3_0f00;
   endfunction

   function automatic dccm_data_t ref_word(input dccm_addr_t addr);
      return ref_mem[word_num(addr)];
   endfunction

   function automatic dccm_addr_t rand_addr();
      logic [31:0] r;
      r = $random(seed);
      return r[DCCM_ADDR_BITS-1:0];
   endfunction

   function automatic dccm_data_t rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r;
   endfunction

   function automatic bank_t rand_bank();
      logic [31:0] r;
      r = $random(seed);
      return r[BANK_BITS-1:0];
   endfunction

   // Any bank but the given one
   function automatic bank_t other_bank(input bank_t b);
      bank_t mask;
      mask = rand_bank();
      if (mask == '0) begin
         mask = bank_t'(1);
      end
      return b ^ mask;
   endfunction

   function automatic dccm_addr_t addr_in_bank(input dccm_addr_t addr, input bank_t b);
      dccm_addr_t a;
      a = addr;
      a[DCCM_OFFSET_BITS +: BANK_BITS] = b;
      return a;
   endfunction

   // High word lands only when the halves sit in different banks
   task automatic model_write(input dccm_addr_t lo, input dccm_addr_t hi,
                              input dccm_data_t d_lo, input dccm_data_t d_hi);
      ref_mem[word_num(lo)] = d_lo;
      if (bank_num(lo) != bank_num(hi)) begin
         ref_mem[word_num(hi)] = d_hi;
      end
   endtask

   task automatic check_value(input string name, input dccm_data_t got,
                              input dccm_data_t expected);
      if (got !== expected) begin
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
         $display("Done: errors found");
         $fatal(1, "read data mismatch");
      end
   endtask

   // One cycle of stimulus; read expectation taken before the write lands
   task automatic issue_cycle(input logic wr_en, input dccm_addr_t w_lo,
                              input dccm_addr_t w_hi, input dccm_data_t d_lo,
                              input dccm_data_t d_hi, input logic rd_en,
                              input dccm_addr_t r_lo, input dccm_addr_t r_hi);
      exp_t e;
      @(posedge clk);
      #(DRIVE_DELAY);
      if (rd_en) begin
         e.due = cycle_cnt + 1;
         e.lo  = ref_word(r_lo);
         e.hi  = (bank_num(r_lo) != bank_num(r_hi)) ? ref_word(r_hi) : ref_word(r_lo);
         exp_q.push_back(e);
      end
      if (wr_en) begin
         model_write(w_lo, w_hi, d_lo, d_hi);
      end
      wr_req.en      = wr_en;
      wr_req.addr_lo = w_lo;
      wr_req.addr_hi = w_hi;
      wr_req.data_lo = d_lo;
      wr_req.data_hi = d_hi;
      rd_req.en      = rd_en;
      rd_req.addr_lo = r_lo;
      rd_req.addr_hi = r_hi;
   endtask

   task automatic write_access(input dccm_addr_t lo, input dccm_addr_t hi,
                               input dccm_data_t d_lo, input dccm_data_t d_hi);
      issue_cycle(1'b1, lo, hi, d_lo, d_hi, 1'b0, '0, '0);
   endtask

   task automatic read_access(input dccm_addr_t lo, input dccm_addr_t hi);
      issue_cycle(1'b0, '0, '0, '0, '0, 1'b1, lo, hi);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #(DRIVE_DELAY);
      wr_req.en = 1'b0;
      rd_req.en = 1'b0;
   endtask

   // Outputs are stable mid-cycle, so sample on the falling edge
   always @(negedge clk) begin : compare_proc
      exp_t e;
      if (compare_cnt < exp_q.size()) begin
         e = exp_q[compare_cnt];
         if (e.due < cycle_cnt) begin
            $display("Read %0d was not compared in the cycle its data was due", compare_cnt);
            $display("Done: errors found");
            $fatal(1, "missed read compare");
         end else if (e.due == cycle_cnt) begin
            check_value("rd_data_lo", rd_data_lo, e.lo);
            check_value("rd_data_hi", rd_data_hi, e.hi);
            compare_cnt = compare_cnt + 1;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: the memory tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Done: errors found");
      $fatal(1, "watchdog timeout");
   end

   initial begin : stimulus
      dccm_addr_t a;
      dccm_addr_t c;
      dccm_addr_t hi;
      bank_t      b;
      logic [31:0] r;
      seed   = 32'h9e068a23;
      reset  = 1'b1;
      wr_req = '0;
      rd_req = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      reset = 1'b0;

      // Give every word a known value, two words per cycle
      for (int w = 0; w < NUM_WORDS; w += 2) begin
         write_access(addr_of(word_t'(w)), addr_of(word_t'(w + 1)),
                      fill_word(word_t'(w)), fill_word(word_t'(w + 1)));
      end

      // Aligned writes, then aligned reads of the same words
      for (int i = 0; i < N_ALIGNED; i++) begin
         a = rand_addr();
         addr_q.push_back(a);
         write_access(a, a, rand_word(), rand_word());
      end
      foreach (addr_q[i]) begin
         read_access(addr_q[i], addr_q[i]);
      end
      addr_q.delete();

      // Unaligned pairs one word apart
      for (int i = 0; i < N_UNALIGNED; i++) begin
         a = rand_addr();
         addr_q.push_back(a);
         write_access(a, dccm_addr_t'(a + WORD_STEP), rand_word(), rand_word());
      end
      foreach (addr_q[i]) begin
         read_access(addr_q[i], dccm_addr_t'(addr_q[i] + WORD_STEP));
      end
      addr_q.delete();

      // Same bank, other index; the high word must stay untouched
      for (int i = 0; i < N_SAME_BANK; i++) begin
         a  = rand_addr();
         hi = dccm_addr_t'(a + BANK_STEP);
         write_access(a, hi, rand_word(), rand_word());
         read_access(hi, hi);
         read_access(a, a);
      end

      // Read and write in one cycle on disjoint banks
      for (int i = 0; i < N_MIXED; i++) begin
         b = rand_bank();
         a = addr_in_bank(rand_addr(), b);
         c = addr_in_bank(rand_addr(), other_bank(b));
         issue_cycle(1'b1, a, a, rand_word(), rand_word(), 1'b1, c, c);
         issue_cycle(1'b1, c, c, rand_word(), rand_word(), 1'b1, a, a);
         read_access(c, c);
      end

      // Back-to-back reads walking through the banks
      b = '0;
      for (int i = 0; i < N_BURST; i++) begin
         a = addr_in_bank(rand_addr(), b);
         r = $random(seed);
         hi = r[0] ? dccm_addr_t'(a + WORD_STEP) : a;
         read_access(a, hi);
         b = bank_t'(b + 1);
      end

      idle_cycle();
      while (compare_cnt != exp_q.size()) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      if (i_dut.i_chk.fail_count == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Bank steering assertions failed %0d times", i_dut.i_chk.fail_count);
         $display("Done: errors found");
         $fatal(1, "assertion failures");
      end
   end

endmodule

// File: build.f
logic/dccm_cfg_pkg.sv
logic/dccm_port_pkg.sv
logic/dccm_bank_steer.sv
logic/dccm_bank_ram.sv
logic/dccm_rd_align.sv
logic/dccm_mem_top.sv
bench/dccm_mem_chk.sv
bench/dccm_mem_tb.sv

// File: logic/dccm_bank_ram.sv
//**********************************************************
// Single-ported memory bank with registered read data
//**********************************************************

module dccm_bank_ram #(
   parameter int NUM_BANKS = 4,
   localparam int BANK_BITS = $clog2(NUM_BANKS),
   localparam int INDEX_BITS =
      dccm_cfg_pkg::DCCM_ADDR_BITS - dccm_cfg_pkg::DCCM_OFFSET_BITS - BANK_BITS
) (
   input  logic                     clk,
   input  logic                     en,
   input  logic                     we,
   input  logic [INDEX_BITS-1:0]    index,
   input  dccm_cfg_pkg::dccm_data_t wdata,
   output dccm_cfg_pkg::dccm_data_t rdata
);

   import dccm_cfg_pkg::*;

   localparam int DEPTH = 1 << INDEX_BITS;

   dccm_data_t mem [DEPTH];

   // Write, or latch the addressed word; idle keeps rdata
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[index] <= wdata;
         end else begin
            rdata <= mem[index];
         end
      end
   end

endmodule

// File: logic/dccm_bank_steer.sv
//**********************************************************
// Bank steering: per-bank enable, index and write data
//**********************************************************

module dccm_bank_steer #(
   parameter int NUM_BANKS = 4,
   localparam int BANK_BITS = $clog2(NUM_BANKS),
   localparam int INDEX_BITS =
      dccm_cfg_pkg::DCCM_ADDR_BITS - dccm_cfg_pkg::DCCM_OFFSET_BITS - BANK_BITS
) (
   input  dccm_port_pkg::dccm_wr_req_t                    wr_req,
   input  dccm_port_pkg::dccm_rd_req_t                    rd_req,
   output logic [NUM_BANKS-1:0]                           bank_we,
   output logic [NUM_BANKS-1:0]                           bank_en,
   output logic [NUM_BANKS-1:0][INDEX_BITS-1:0]           bank_index,
   output dccm_cfg_pkg::dccm_data_t [NUM_BANKS-1:0]       bank_wdata
);

   import dccm_cfg_pkg::*;

   typedef logic [BANK_BITS-1:0]  bank_t;
   typedef logic [INDEX_BITS-1:0] index_t;

   // Bank field sits right above the byte offset
   function automatic bank_t bank_of(input dccm_addr_t addr);
      return addr[DCCM_OFFSET_BITS +: BANK_BITS];
   endfunction

   // Index field sits above the bank field
   function automatic index_t index_of(input dccm_addr_t addr);
      return addr[DCCM_OFFSET_BITS + BANK_BITS +: INDEX_BITS];
   endfunction

   bank_t  wr_lo_bank;
   bank_t  wr_hi_bank;
   bank_t  rd_lo_bank;
   bank_t  rd_hi_bank;
   index_t wr_lo_index;
   index_t wr_hi_index;
   index_t rd_lo_index;
   index_t rd_hi_index;
   logic   wr_unaligned;
   logic   rd_unaligned;

   assign wr_lo_bank  = bank_of(wr_req.addr_lo);
   assign wr_hi_bank  = bank_of(wr_req.addr_hi);
   assign rd_lo_bank  = bank_of(rd_req.addr_lo);
   assign rd_hi_bank  = bank_of(rd_req.addr_hi);

   assign wr_lo_index = index_of(wr_req.addr_lo);
   assign wr_hi_index = index_of(wr_req.addr_hi);
   assign rd_lo_index = index_of(rd_req.addr_lo);
   assign rd_hi_index = index_of(rd_req.addr_hi);

   // Two adjacent words only when the halves land in different banks
   assign wr_unaligned = (wr_lo_bank != wr_hi_bank);
   assign rd_unaligned = (rd_lo_bank != rd_hi_bank);

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      logic wr_hit;
      logic rd_hit;
      logic wr_use_hi;
      logic rd_use_hi;
      index_t wr_index;
      index_t rd_index;

      assign wr_hit = wr_req.en &&
                      ((wr_lo_bank == bank_t'(i)) || (wr_hi_bank == bank_t'(i)));
      assign rd_hit = rd_req.en &&
                      ((rd_lo_bank == bank_t'(i)) || (rd_hi_bank == bank_t'(i)));

      // High half owns this bank only for an unaligned access
      assign wr_use_hi = wr_unaligned && (wr_hi_bank == bank_t'(i));
      assign rd_use_hi = rd_unaligned && (rd_hi_bank == bank_t'(i));

      assign wr_index = wr_use_hi ? wr_hi_index : wr_lo_index;
      assign rd_index = rd_use_hi ? rd_hi_index : rd_lo_index;

      assign bank_we[i]    = wr_hit;
      assign bank_en[i]    = wr_hit || rd_hit;

      // Write wins the single port of the bank
      assign bank_index[i] = wr_hit ? wr_index : rd_index;
      assign bank_wdata[i] = wr_use_hi ? wr_req.data_hi : wr_req.data_lo;
   end : g_bank

endmodule

// File: logic/dccm_cfg_pkg.sv
//**********************************************************
// Data memory configuration: address and data sizes
//**********************************************************

package dccm_cfg_pkg;

   // Byte address width for 4 KB in total
   localparam int DCCM_ADDR_BITS = 12;

   // One data word with no check bits
   localparam int DCCM_DATA_BITS = 32;

   // Byte offset inside a 32-bit word
   localparam int DCCM_OFFSET_BITS = 2;

   typedef logic [DCCM_ADDR_BITS-1:0] dccm_addr_t;

   typedef logic [DCCM_DATA_BITS-1:0] dccm_data_t;

endpackage

// File: logic/dccm_mem_top.sv
//**********************************************************
// Banked data memory for the load/store pipe
//**********************************************************

module dccm_mem_top #(
   parameter int NUM_BANKS = 4
) (
   input  logic                        clk,
   input  logic                        reset,
   input  dccm_port_pkg::dccm_wr_req_t wr_req,
   input  dccm_port_pkg::dccm_rd_req_t rd_req,
   output dccm_cfg_pkg::dccm_data_t    rd_data_lo,
   output dccm_cfg_pkg::dccm_data_t    rd_data_hi
);

   import dccm_cfg_pkg::*;

   localparam int BANK_BITS  = $clog2(NUM_BANKS);
   localparam int INDEX_BITS = DCCM_ADDR_BITS - DCCM_OFFSET_BITS - BANK_BITS;

   logic [NUM_BANKS-1:0]                 bank_we;
   logic [NUM_BANKS-1:0]                 bank_en;
   logic [NUM_BANKS-1:0][INDEX_BITS-1:0] bank_index;
   dccm_data_t [NUM_BANKS-1:0]           bank_wdata;
   dccm_data_t [NUM_BANKS-1:0]           bank_rdata;

   dccm_bank_steer #(
      .NUM_BANKS (NUM_BANKS)
   ) i_steer (
      .wr_req     (wr_req),
      .rd_req     (rd_req),
      .bank_we    (bank_we),
      .bank_en    (bank_en),
      .bank_index (bank_index),
      .bank_wdata (bank_wdata)
   );

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      dccm_bank_ram #(
         .NUM_BANKS (NUM_BANKS)
      ) i_ram (
         .clk   (clk),
         .en    (bank_en[i]),
         .we    (bank_we[i]),
         .index (bank_index[i]),
         .wdata (bank_wdata[i]),
         .rdata (bank_rdata[i])
      );
   end : g_bank

   // Read data lines up with the bank numbers captured at the read
   dccm_rd_align #(
      .NUM_BANKS (NUM_BANKS)
   ) i_align (
      .clk        (clk),
      .reset      (reset),
      .rd_addr_lo (rd_req.addr_lo),
      .rd_addr_hi (rd_req.addr_hi),
      .bank_rdata (bank_rdata),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

endmodule

// File: logic/dccm_port_pkg.sv
//**********************************************************
// Data memory ports: write and read request bundles
//**********************************************************

package dccm_port_pkg;

   import dccm_cfg_pkg::*;

   // addr_hi and data_hi only matter for an unaligned write
   typedef struct packed {
      logic       en;
      dccm_addr_t addr_lo;
      dccm_addr_t addr_hi;
      dccm_data_t data_lo;
      dccm_data_t data_hi;
   } dccm_wr_req_t;

   // Both read halves come back one clock later
   typedef struct packed {
      logic       en;
      dccm_addr_t addr_lo;
      dccm_addr_t addr_hi;
   } dccm_rd_req_t;

endpackage

// File: logic/dccm_rd_align.sv
//**********************************************************
// Read aligner: steers bank outputs to low and high data
//**********************************************************

module dccm_rd_align #(
   parameter int NUM_BANKS = 4,
   localparam int BANK_BITS = $clog2(NUM_BANKS)
) (
   input  logic                                     clk,
   input  logic                                     reset,
   input  dccm_cfg_pkg::dccm_addr_t                 rd_addr_lo,
   input  dccm_cfg_pkg::dccm_addr_t                 rd_addr_hi,
   input  dccm_cfg_pkg::dccm_data_t [NUM_BANKS-1:0] bank_rdata,
   output dccm_cfg_pkg::dccm_data_t                 rd_data_lo,
   output dccm_cfg_pkg::dccm_data_t                 rd_data_hi
);

   import dccm_cfg_pkg::*;

   logic [BANK_BITS-1:0] lo_bank_q;
   logic [BANK_BITS-1:0] hi_bank_q;

   // Bank numbers follow the bank read latency by one clock
   always_ff @(posedge clk) begin
      if (reset) begin
         lo_bank_q <= '0;
         hi_bank_q <= '0;
      end else begin
         lo_bank_q <= rd_addr_lo[DCCM_OFFSET_BITS +: BANK_BITS];
         hi_bank_q <= rd_addr_hi[DCCM_OFFSET_BITS +: BANK_BITS];
      end
   end

   // For an aligned read both select the same bank
   assign rd_data_lo = bank_rdata[lo_bank_q];
   assign rd_data_hi = bank_rdata[hi_bank_q];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the data memory testbench with Verilator.
# Exit status is 0 only when the pass message shows up in the output.

set -u

cd "$(dirname "$0")" || exit 1

TOP=dccm_mem_tb
BUILD_DIR=obj_dir
PASS_MSG="Done: no errors"

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR" \
   -f build.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Compile failed with status $status"
   exit 1
fi

# Let assertion failures reach the end of the run instead of stopping it
sim_out=$("./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$sim_out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF "$PASS_MSG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
